//--- filelist.f
ramio_pkg.sv
ramio.sv
wordram.sv
uarttx.sv
uartrx.sv
ramio_top.sv
tb_ramio.sv

//--- ramio.sv
//------------------------------------------------
// ramio
// decodes client accesses to the word RAM, LEDs
// and UART, builds byte lanes for RAM writes and
// extends RAM read lanes by sign or zero
//------------------------------------------------
module ramio
  import ramio_pkg::*;
#(
  parameter int ram_addr_width = 10
) (
  input  logic                      clk,
  input  logic                      rst_n,
  // client side
  input  logic                      enable,
  input  read_type_e                read_type,
  input  write_type_e               write_type,
  input  logic [addr_width-1:0]     address,
  input  logic [data_width-1:0]     data_in,
  output logic [data_width-1:0]     data_out,
  output logic                      data_out_ready,
  output logic                      busy,
  output logic [3:0]                led,
  // word RAM
  output logic                      ram_enable,
  output logic [ram_addr_width-1:0] ram_word_addr,
  output logic [3:0]                ram_write_enable,
  output logic [data_width-1:0]     ram_data_in,
  input  logic [data_width-1:0]     ram_data_out,
  input  logic                      ram_ready,
  input  logic                      ram_busy,
  // UART transmitter
  output logic [7:0]                tx_data,
  output logic                      tx_go,
  input  logic                      tx_bsy,
  // UART receiver
  input  logic [7:0]                rx_data,
  input  logic                      rx_ready,
  output logic                      rx_go
);

  // port decode
  logic is_led;
  logic is_tx;
  logic is_rx;
  logic is_io;
  logic is_read;
  logic is_write;

  // byte being sent, all ones when idle
  logic [data_width-1:0] tx_readback;
  // go was raised in the previous cycle, bsy not yet valid
  logic                  tx_go_prev;
  // last byte received, all ones when empty
  logic [data_width-1:0] rx_latch;

  // lanes picked out of the RAM word
  logic [7:0]  byte_lane;
  logic [15:0] half_lane;

  assign is_led   = address == addr_led;
  assign is_tx    = address == addr_uart_out;
  assign is_rx    = address == addr_uart_in;
  assign is_io    = is_led || is_tx || is_rx;
  assign is_read  = enable && read_type != rd_none;
  assign is_write = enable && write_type != wr_none;

  // I/O answers at once, RAM handshake is forwarded
  assign busy           = is_io ? 1'b0 : ram_busy;
  assign data_out_ready = is_io ? 1'b1 : ram_ready;

  //------------------------------------------------
  // RAM write lanes
  //------------------------------------------------
  assign ram_enable    = (is_read || is_write) && !is_io;
  assign ram_word_addr = address[ram_addr_width+1:2];

  always_comb begin
    ram_write_enable = 4'b0000;
    ram_data_in      = data_in;
    case (write_type)
      // byte replicated on all lanes, one enable
      wr_byte: begin
        ram_write_enable = 4'b0001 << address[1:0];
        ram_data_in      = {4{data_in[7:0]}};
      end
      wr_half: begin
        ram_write_enable = address[1] ? 4'b1100 : 4'b0011;
        ram_data_in      = {2{data_in[15:0]}};
      end
      wr_word: ram_write_enable = 4'b1111;
      default: ram_write_enable = 4'b0000;
    endcase
    // no write strobe on I/O cycles or while idle
    if (!ram_enable) begin
      ram_write_enable = 4'b0000;
    end
  end

  //------------------------------------------------
  // read data
  //------------------------------------------------
  assign byte_lane = ram_data_out[{address[1:0], 3'b000} +: 8];
  assign half_lane = address[1] ? ram_data_out[31:16] : ram_data_out[15:0];

  always_comb begin
    data_out = '0;
    if (is_read) begin
      if (is_led) begin
        data_out = data_width'(led);
      end else if (is_tx) begin
        data_out = tx_readback;
      end else if (is_rx) begin
        data_out = rx_latch;
      end else begin
        case (read_type)
          rd_byte_u: data_out = data_width'(byte_lane);
          rd_byte_s: data_out = data_width'(signed'(byte_lane));
          rd_half_u: data_out = data_width'(half_lane);
          rd_half_s: data_out = data_width'(signed'(half_lane));
          rd_word:   data_out = ram_data_out;
          default:   data_out = '0;
        endcase
      end
    end
  end

  //------------------------------------------------
  // LED register and UART handshakes
  //------------------------------------------------
  assign tx_data = tx_readback[7:0];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      // all LEDs dark
      led         <= 4'b1111;
      tx_readback <= uart_idle_word;
      tx_go       <= 1'b0;
      tx_go_prev  <= 1'b0;
      rx_latch    <= uart_idle_word;
      rx_go       <= 1'b1;
    end else begin
      tx_go_prev <= 1'b0;

      // a read empties the receive latch, otherwise take a new byte
      // a byte not yet read is overrun
      if (is_read && is_rx) begin
        rx_latch <= uart_idle_word;
      end else if (rx_go && rx_ready) begin
        rx_latch <= data_width'(rx_data);
        // drop go for one cycle as acknowledge
        rx_go    <= 1'b0;
      end
      if (!rx_go) begin
        rx_go <= 1'b1;
      end

      // frame done, release the transmitter
      if (tx_go && !tx_bsy && !tx_go_prev) begin
        tx_go       <= 1'b0;
        tx_readback <= uart_idle_word;
      end

      // new byte to send, wins over the release above
      if (is_write && is_tx) begin
        tx_readback <= data_width'(data_in[7:0]);
        tx_go       <= 1'b1;
        tx_go_prev  <= 1'b1;
      end

      if (is_write && is_led) begin
        led <= data_in[3:0];
      end
    end
  end

  // half-word and word accesses arrive naturally aligned
  assert property (@(posedge clk) disable iff (!rst_n)
    enable && (read_type inside {rd_half_u, rd_half_s} || write_type == wr_half)
    |-> !address[0]);
  assert property (@(posedge clk) disable iff (!rst_n)
    enable && (read_type == rd_word || write_type == wr_word)
    |-> address[1:0] == 2'b00);

endmodule

//--- ramio_pkg.sv
//------------------------------------------------
// ramio package
// access kinds, I/O port addresses and data widths
// shared by the I/O subsystem and its testbench
//------------------------------------------------
package ramio_pkg;

  // client bus widths
  localparam int data_width = 32;
  localparam int addr_width = 32;

  // read kind: bits 1:0 give the size, bit 2 flags sign extension
  // word reads carry bit 2 set, as the processor issues them
  typedef enum logic [2:0] {
    rd_none   = 3'b000,
    rd_byte_u = 3'b001,
    rd_half_u = 3'b010,
    rd_word   = 3'b111,
    rd_byte_s = 3'b101,
    rd_half_s = 3'b110
  } read_type_e;

  // write kind, same size coding as the read kind
  typedef enum logic [1:0] {
    wr_none = 2'b00,
    wr_byte = 2'b01,
    wr_half = 2'b10,
    wr_word = 2'b11
  } write_type_e;

  //------------------------------------------------
  // memory-mapped I/O ports at the top of the space
  //------------------------------------------------
  // four LEDs in the low nibble, 0 lights a LED
  localparam logic [addr_width-1:0] addr_led      = 32'hffff_fffc;
  // byte being sent, all ones when idle
  localparam logic [addr_width-1:0] addr_uart_out = 32'hffff_fff8;
  // last byte received, all ones when empty, cleared by a read
  localparam logic [addr_width-1:0] addr_uart_in  = 32'hffff_fff4;

  // readback of an idle transmitter or an empty receiver
  localparam logic [data_width-1:0] uart_idle_word = '1;

endpackage

//--- ramio_top.sv
//------------------------------------------------
// ramio_top
// I/O subsystem: decoder, word RAM and UART pair
//------------------------------------------------
module ramio_top
  import ramio_pkg::*;
#(
  parameter int ram_addr_width     = 10,
  parameter int clock_frequency_hz = 50_000_000,
  parameter int baud_rate          = 115_200
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  enable,
  input  read_type_e            read_type,
  input  write_type_e           write_type,
  input  logic [addr_width-1:0] address,
  input  logic [data_width-1:0] data_in,
  input  logic                  uart_rx,
  output logic [data_width-1:0] data_out,
  output logic                  data_out_ready,
  output logic                  busy,
  output logic [3:0]            led,
  output logic                  uart_tx
);

  // bit time shared by both UART directions
  localparam int clks_per_bit = clock_frequency_hz / baud_rate;

  // decoder to word RAM
  logic                      ram_enable;
  logic [ram_addr_width-1:0] ram_word_addr;
  logic [3:0]                ram_write_enable;
  logic [data_width-1:0]     ram_data_in;
  logic [data_width-1:0]     ram_data_out;
  logic                      ram_ready;
  logic                      ram_busy;

  // decoder to UART pair
  logic [7:0] tx_data;
  logic       tx_go;
  logic       tx_bsy;
  logic [7:0] rx_data;
  logic       rx_ready;
  logic       rx_go;

  ramio #(
    .ram_addr_width(ram_addr_width)
  ) u_ramio (
    .clk             (clk),
    .rst_n           (rst_n),
    .enable          (enable),
    .read_type       (read_type),
    .write_type      (write_type),
    .address         (address),
    .data_in         (data_in),
    .data_out        (data_out),
    .data_out_ready  (data_out_ready),
    .busy            (busy),
    .led             (led),
    .ram_enable      (ram_enable),
    .ram_word_addr   (ram_word_addr),
    .ram_write_enable(ram_write_enable),
    .ram_data_in     (ram_data_in),
    .ram_data_out    (ram_data_out),
    .ram_ready       (ram_ready),
    .ram_busy        (ram_busy),
    .tx_data         (tx_data),
    .tx_go           (tx_go),
    .tx_bsy          (tx_bsy),
    .rx_data         (rx_data),
    .rx_ready        (rx_ready),
    .rx_go           (rx_go)
  );

  wordram #(
    .ram_addr_width(ram_addr_width)
  ) u_wordram (
    .clk           (clk),
    .rst_n         (rst_n),
    .enable        (ram_enable),
    .word_addr     (ram_word_addr),
    .write_enable  (ram_write_enable),
    .data_in       (ram_data_in),
    .data_out      (ram_data_out),
    .data_out_ready(ram_ready),
    .busy          (ram_busy)
  );

  uarttx #(
    .clks_per_bit(clks_per_bit)
  ) u_uarttx (
    .clk  (clk),
    .rst_n(rst_n),
    .data (tx_data),
    .go   (tx_go),
    .tx   (uart_tx),
    .bsy  (tx_bsy)
  );

  uartrx #(
    .clks_per_bit(clks_per_bit)
  ) u_uartrx (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx        (uart_rx),
    .go        (rx_go),
    .data      (rx_data),
    .data_ready(rx_ready)
  );

endmodule

//--- run.sh
#!/bin/sh
# build and run the ramio testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_ramio -f filelist.f -o tb_ramio_sim

# the simulation exits non-zero on failure, the log decides
./obj_dir/tb_ramio_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Testbench passed" sim.log; then
  exit 0
else
  exit 1
fi

//--- tb_ramio.sv
//------------------------------------------------
// tb_ramio
// random self-checking testbench for the I/O
// subsystem, with a byte model of the word RAM,
// a serial line driver and a frame decoder
//------------------------------------------------
module tb_ramio
  import ramio_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int ram_addr_width = 6;
  localparam int clock_hz       = 1_000_000;
  localparam int baud           = 125_000;
  localparam int clks_per_bit   = clock_hz / baud;
  localparam int ram_bytes      = 4 << ram_addr_width;

  // operations per test, a tx frame is one write and two reads
  localparam int num_ops = 3 + 64 + 200 + 2 * 40 + 60 + 2 * 8 + 3 * 4 + 2 * 16;
  // 4 tx frames plus 16 rx frames
  localparam int watchdog_cycles = num_ops * 200 + 20 * 10 * clks_per_bit;

  logic                  clk = 1'b0;
  logic                  rst_n;
  logic                  enable;
  read_type_e            read_type;
  write_type_e           write_type;
  logic [addr_width-1:0] address;
  logic [data_width-1:0] data_in;
  logic                  uart_rx;
  logic [data_width-1:0] data_out;
  logic                  data_out_ready;
  logic                  busy;
  logic [3:0]            led;
  logic                  uart_tx;

  // random source and RAM model, byte 0 sits in lane 0
  logic [31:0] lfsr;
  logic [7:0]  mem_model [ram_bytes];

  ramio_top #(
    .ram_addr_width    (ram_addr_width),
    .clock_frequency_hz(clock_hz),
    .baud_rate         (baud)
  ) u_dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .enable        (enable),
    .read_type     (read_type),
    .write_type    (write_type),
    .address       (address),
    .data_in       (data_in),
    .uart_rx       (uart_rx),
    .data_out      (data_out),
    .data_out_ready(data_out_ready),
    .busy          (busy),
    .led           (led),
    .uart_tx       (uart_tx)
  );

  initial begin
    forever #5 clk = ~clk;
  end

  //------------------------------------------------
  // failure reporting and random bits
  //------------------------------------------------
  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] expected);
    if (got !== expected) begin
      fail_run($sformatf("mismatch %s got %h expected %h", name, got, expected));
    end
  endtask

  // fibonacci LFSR x^32+x^22+x^2+x+1, one step per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v    = {v[30:0], fb};
    end
    return v;
  endfunction

  //------------------------------------------------
  // RAM model
  //------------------------------------------------
  function automatic void model_write(input logic [7:0] a, input write_type_e wt,
                                      input logic [31:0] d);
    mem_model[a] = d[7:0];
    if (wt != wr_byte) begin
      mem_model[a + 8'd1] = d[15:8];
    end
    if (wt == wr_word) begin
      mem_model[a + 8'd2] = d[23:16];
      mem_model[a + 8'd3] = d[31:24];
    end
  endfunction

  // lane picked by the low address bits, extended by the kind of read
  function automatic logic [31:0] expect_read(input logic [7:0] a, input read_type_e rt);
    logic [7:0] lo;
    logic [7:0] hi;
    lo = mem_model[a];
    hi = mem_model[a + 8'd1];
    case (rt)
      rd_byte_u: return {24'h000000, lo};
      rd_byte_s: return {{24{lo[7]}}, lo};
      rd_half_u: return {16'h0000, hi, lo};
      rd_half_s: return {{16{hi[7]}}, hi, lo};
      default:   return {mem_model[a + 8'd3], mem_model[a + 8'd2], hi, lo};
    endcase
  endfunction

  //------------------------------------------------
  // client bus, called and returning on a falling edge
  //------------------------------------------------
  task automatic release_bus();
    enable     = 1'b0;
    read_type  = rd_none;
    write_type = wr_none;
    // one idle cycle between accesses
    @(negedge clk);
  endtask

  task automatic bus_write(input logic [31:0] addr, input write_type_e wt,
                           input logic [31:0] wdata);
    int cycles;
    enable     = 1'b1;
    read_type  = rd_none;
    write_type = wt;
    address    = addr;
    data_in    = wdata;
    cycles     = 0;
    #2;
    while (busy) begin
      cycles++;
      if (cycles > 4) begin
        fail_run($sformatf("write to %h still busy after 4 cycles", addr));
      end
      @(negedge clk);
      #2;
    end
    // accepted at the next rising edge
    @(negedge clk);
    release_bus();
  endtask

  task automatic bus_read(input logic [31:0] addr, input read_type_e rt,
                          output logic [31:0] rdata);
    int cycles;
    enable     = 1'b1;
    read_type  = rt;
    write_type = wr_none;
    address    = addr;
    cycles     = 0;
    #2;
    while (!data_out_ready) begin
      cycles++;
      if (cycles > 4) begin
        fail_run($sformatf("read of %h not ready after 4 cycles", addr));
      end
      @(negedge clk);
      #2;
    end
    rdata = data_out;
    @(negedge clk);
    release_bus();
  endtask

  //------------------------------------------------
  // serial line
  //------------------------------------------------
  // start bit, data LSB first, stop bit
  task automatic send_frame(input logic [7:0] b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      uart_rx = frame[i];
      repeat (clks_per_bit) @(negedge clk);
    end
    // two-flop synchronizer delay
    repeat (2) @(negedge clk);
  endtask

  // samples uart_tx near each bit centre, on falling edges
  task automatic decode_frame(output logic [7:0] b);
    int waited;
    waited = 0;
    while (uart_tx) begin
      waited++;
      if (waited > 4) begin
        fail_run("no start bit on uart_tx after the transmit write");
      end
      @(negedge clk);
    end
    repeat (clks_per_bit / 2 - 1) @(negedge clk);
    check("uart_tx start bit", 32'(uart_tx), 32'h0);
    for (int i = 0; i < 8; i++) begin
      repeat (clks_per_bit) @(negedge clk);
      b[i] = uart_tx;
    end
    repeat (clks_per_bit) @(negedge clk);
    check("uart_tx stop bit", 32'(uart_tx), 32'h1);
  endtask

  //------------------------------------------------
  // tests
  //------------------------------------------------
  task automatic check_reset_state();
    logic [31:0] v;
    check("led", 32'(led), 32'hf);
    check("uart_tx", 32'(uart_tx), 32'h1);
    bus_read(addr_led, rd_word, v);
    check("data_out led", v, 32'hf);
    bus_read(addr_uart_out, rd_word, v);
    check("data_out uart_out", v, uart_idle_word);
    bus_read(addr_uart_in, rd_word, v);
    check("data_out uart_in", v, uart_idle_word);
  endtask

  task automatic test_word_storage();
    logic [31:0] v;
    logic [31:0] w;
    logic [7:0]  a;
    // fill every word first so that no read sees unwritten data
    for (int i = 0; i < 64; i++) begin
      w = take_bits(32);
      a = 8'(i * 4);
      bus_write(32'(a), wr_word, w);
      model_write(a, wr_word, w);
    end
    for (int i = 0; i < 200; i++) begin
      a = 8'(take_bits(6) << 2);
      if (take_bits(1) != 0) begin
        w = take_bits(32);
        bus_write(32'(a), wr_word, w);
        model_write(a, wr_word, w);
      end else begin
        bus_read(32'(a), rd_word, v);
        check("data_out word", v, expect_read(a, rd_word));
      end
    end
  endtask

  task automatic test_subword_writes();
    logic [31:0] v;
    logic [31:0] w;
    logic [7:0]  a;
    write_type_e wt;
    for (int i = 0; i < 40; i++) begin
      a = 8'(take_bits(6) << 2);
      if (take_bits(1) != 0) begin
        wt = wr_byte;
        a  = a | 8'(take_bits(2));
      end else begin
        wt = wr_half;
        a  = a | 8'(take_bits(1) << 1);
      end
      w = take_bits(32);
      bus_write(32'(a), wt, w);
      model_write(a, wt, w);
      // whole word shows which lanes changed
      a = a & 8'hfc;
      bus_read(32'(a), rd_word, v);
      check("data_out word after sub-word write", v, expect_read(a, rd_word));
    end
  endtask

  task automatic test_subword_reads();
    logic [31:0] v;
    logic [7:0]  a;
    read_type_e  rt;
    for (int i = 0; i < 60; i++) begin
      a = 8'(take_bits(6) << 2);
      case (take_bits(2))
        32'd0:   rt = rd_byte_u;
        32'd1:   rt = rd_byte_s;
        32'd2:   rt = rd_half_u;
        default: rt = rd_half_s;
      endcase
      if (rt == rd_byte_u || rt == rd_byte_s) begin
        a = a | 8'(take_bits(2));
      end else begin
        a = a | 8'(take_bits(1) << 1);
      end
      bus_read(32'(a), rt, v);
      check($sformatf("data_out %s", rt.name()), v, expect_read(a, rt));
    end
  endtask

  task automatic test_led_and_tx();
    logic [31:0] v;
    logic [31:0] w;
    logic [7:0]  got;
    for (int i = 0; i < 8; i++) begin
      w = take_bits(32);
      bus_write(addr_led, wr_word, w);
      check("led", 32'(led), 32'(w[3:0]));
      bus_read(addr_led, rd_word, v);
      check("data_out led", v, 32'(w[3:0]));
    end
    for (int i = 0; i < 4; i++) begin
      w = take_bits(32);
      bus_write(addr_uart_out, wr_word, w);
      // readback is taken during the start bit
      fork
        decode_frame(got);
        begin
          @(negedge clk);
          bus_read(addr_uart_out, rd_word, v);
          check("data_out uart_out while sending", v, 32'(w[7:0]));
        end
      join
      check("uart_tx byte", 32'(got), 32'(w[7:0]));
      // rest of the stop bit, then go is dropped
      repeat (clks_per_bit / 2 + 3) @(negedge clk);
      bus_read(addr_uart_out, rd_word, v);
      check("data_out uart_out after frame", v, uart_idle_word);
    end
  endtask

  task automatic test_receive();
    logic [31:0] v;
    logic [7:0]  b;
    for (int i = 0; i < 16; i++) begin
      b = 8'(take_bits(8));
      send_frame(b);
      bus_read(addr_uart_in, rd_word, v);
      check("data_out uart_in", v, 32'(b));
      // the first read emptied the latch
      bus_read(addr_uart_in, rd_word, v);
      check("data_out uart_in second read", v, uart_idle_word);
    end
  endtask

  initial begin
    lfsr       = 32'he9f44d5c;
    rst_n      = 1'b0;
    enable     = 1'b0;
    read_type  = rd_none;
    write_type = wr_none;
    address    = '0;
    data_in    = '0;
    uart_rx    = 1'b1;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    check_reset_state();
    test_word_storage();
    test_subword_writes();
    test_subword_reads();
    test_led_and_tx();
    test_receive();

    $display("Testbench passed");
    $finish;
  end

  // watchdog sized from the operation count and frame count
  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    fail_run($sformatf("timeout, run did not finish within %0d cycles", watchdog_cycles));
  end

endmodule

//--- uartrx.sv
//------------------------------------------------
// uartrx
// UART receiver, 8N1, samples each bit mid-way
// holds the byte until go falls as acknowledge
//------------------------------------------------
module uartrx #(
  parameter int clks_per_bit = 8
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       rx,
  input  logic       go,
  output logic [7:0] data,
  output logic       data_ready
);

  localparam int baud_w = $clog2(clks_per_bit + 1);
  localparam logic [baud_w-1:0] baud_last = baud_w'(clks_per_bit - 1);
  localparam logic [baud_w-1:0] baud_half = baud_w'(clks_per_bit / 2 - 1);

  typedef enum logic [2:0] {
    rx_idle,
    rx_start,
    rx_data,
    rx_stop,
    rx_full
  } rx_state_e;

  rx_state_e         state;
  // two-flop synchronizer on the serial line
  logic              rx_meta;
  logic              rx_sync;
  logic [baud_w-1:0] baud_cnt;
  logic [2:0]        bit_cnt;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state      <= rx_idle;
      data_ready <= 1'b0;
      baud_cnt   <= '0;
      bit_cnt    <= '0;
    end else begin
      baud_cnt <= baud_cnt + 1'b1;
      case (state)
        // hunt for a falling edge while the client wants data
        rx_idle: begin
          baud_cnt <= '0;
          if (go && !rx_sync) begin
            state <= rx_start;
          end
        end
        // confirm the start bit half a bit later, else a glitch
        rx_start: begin
          if (baud_cnt == baud_half) begin
            baud_cnt <= '0;
            bit_cnt  <= '0;
            state    <= rx_sync ? rx_idle : rx_data;
          end
        end
        // one full bit from mid start lands mid data bit
        rx_data: begin
          if (baud_cnt == baud_last) begin
            baud_cnt <= '0;
            data     <= {rx_sync, data[7:1]};
            bit_cnt  <= bit_cnt + 1'b1;
            if (bit_cnt == 3'd7) begin
              state <= rx_stop;
            end
          end
        end
        // framing error drops the byte
        rx_stop: begin
          if (baud_cnt == baud_last) begin
            if (rx_sync) begin
              data_ready <= 1'b1;
              state      <= rx_full;
            end else begin
              state <= rx_idle;
            end
          end
        end
        rx_full: begin
          baud_cnt <= '0;
          if (!go) begin
            data_ready <= 1'b0;
            state      <= rx_idle;
          end
        end
        default: state <= rx_idle;
      endcase
    end
  end

endmodule

//--- uarttx.sv
//------------------------------------------------
// uarttx
// UART transmitter, 8N1, LSB first
// go starts a frame, bsy falls after the stop bit
//------------------------------------------------
module uarttx #(
  parameter int clks_per_bit = 8
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic [7:0] data,
  input  logic       go,
  output logic       tx,
  output logic       bsy
);

  localparam int baud_w = $clog2(clks_per_bit + 1);
  localparam logic [baud_w-1:0] baud_last = baud_w'(clks_per_bit - 1);

  typedef enum logic [2:0] {
    tx_idle,
    tx_start,
    tx_data,
    tx_stop,
    tx_done
  } tx_state_e;

  tx_state_e         state;
  logic [baud_w-1:0] baud_cnt;
  logic [2:0]        bit_cnt;
  logic [7:0]        shift;
  // last clock of the current bit
  logic              baud_tick;

  assign baud_tick = baud_cnt == baud_last;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= tx_idle;
      tx       <= 1'b1;
      bsy      <= 1'b0;
      baud_cnt <= '0;
      bit_cnt  <= '0;
    end else begin
      baud_cnt <= baud_tick ? '0 : baud_cnt + 1'b1;
      case (state)
        tx_idle: begin
          baud_cnt <= '0;
          if (go) begin
            // start bit goes out on this edge
            shift <= data;
            tx    <= 1'b0;
            bsy   <= 1'b1;
            state <= tx_start;
          end
        end
        tx_start: begin
          if (baud_tick) begin
            tx      <= shift[0];
            bit_cnt <= '0;
            state   <= tx_data;
          end
        end
        tx_data: begin
          if (baud_tick) begin
            if (bit_cnt == 3'd7) begin
              tx    <= 1'b1;
              state <= tx_stop;
            end else begin
              tx      <= shift[1];
              shift   <= {1'b0, shift[7:1]};
              bit_cnt <= bit_cnt + 1'b1;
            end
          end
        end
        tx_stop: begin
          if (baud_tick) begin
            bsy   <= 1'b0;
            state <= tx_done;
          end
        end
        // wait for the client to drop go
        tx_done: begin
          if (!go) begin
            state <= tx_idle;
          end
        end
        default: state <= tx_idle;
      endcase
    end
  end

  // idle line is marking and the transmitter is free
  assert property (@(posedge clk) disable iff (!rst_n)
    state == tx_idle |-> tx && !bsy);

endmodule

//--- wordram.sv
//------------------------------------------------
// wordram
// single-port word RAM with byte write enables,
// registered read and a ready flag
//------------------------------------------------
module wordram
  import ramio_pkg::*;
#(
  parameter int ram_addr_width = 10
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      enable,
  input  logic [ram_addr_width-1:0] word_addr,
  input  logic [3:0]                write_enable,
  input  logic [data_width-1:0]     data_in,
  output logic [data_width-1:0]     data_out,
  output logic                      data_out_ready,
  output logic                      busy
);

  localparam int depth = 1 << ram_addr_width;

  logic [data_width-1:0]     mem [depth];
  // stored word with the write lanes merged in
  logic [data_width-1:0]     merged;
  // address of the word held in data_out
  logic [ram_addr_width-1:0] addr_q;
  // data_out holds a word from an enabled cycle
  logic                      valid_q;

  always_comb begin
    merged = mem[word_addr];
    for (int i = 0; i < 4; i++) begin
      if (write_enable[i]) begin
        merged[8*i +: 8] = data_in[8*i +: 8];
      end
    end
  end

  // array and read register
  // the read register sees the freshly written word too
  always_ff @(posedge clk) begin
    if (enable) begin
      if (write_enable != 4'b0000) begin
        mem[word_addr] <= merged;
      end
      data_out <= merged;
      addr_q   <= word_addr;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= enable;
    end
  end

  // ready once the held word belongs to the current address
  assign data_out_ready = enable && valid_q && addr_q == word_addr;
  assign busy           = enable && !data_out_ready;

  // a ready word is enabled and agrees with the array
  assert property (@(posedge clk) disable iff (!rst_n)
    data_out_ready |-> enable && data_out == mem[word_addr]);

endmodule
